// File: bench/lsu_addr_golden.txt
# flag rs1 imm type mode vaddr except, flag L=load S=store, rs1 imm vaddr in hex
# type 0 B 1 BU 2 H 3 HU 4 W 5 WU 6 D, mode 0 BARE 8 SV39 9 SV48, except 0 none 1 align 2 page
# BARE, alignment only, negative immediates and wrap-around
L 0000000000001000 010 6 0 0000000000001010 0
S 0000000000002000 ff8 6 0 0000000000001ff8 0
L 0000000000000100 001 0 0 0000000000000101 0
S 0000000000000100 003 1 0 0000000000000103 0
L 0000000080000000 002 2 0 0000000080000002 0
S 0000000080000000 7ff 3 0 00000000800007ff 1
L 0000000000003000 ffd 4 0 0000000000002ffd 1
S 0000000000003000 ffe 5 0 0000000000002ffe 1
L 0000000000003000 ffc 4 0 0000000000002ffc 0
S 00000000000040f0 004 6 0 00000000000040f4 1
L ffffffffffffffff 001 6 0 0000000000000000 0
S 0000000000000000 fff 0 0 ffffffffffffffff 0
L 0000000000000005 800 0 0 fffffffffffff805 0
S 123456789abcdef0 7f8 6 0 123456789abce6e8 0
L 0000000000001001 000 1 0 0000000000001001 0
S 0000000000001006 001 2 0 0000000000001007 1
# SV39, upper bits must copy bit 38
L 0000003ffffffff0 008 6 8 0000003ffffffff8 0
S 0000003ffffffff8 008 6 8 0000004000000000 2
L ffffffc000000000 ff8 6 8 ffffffbffffffff8 2
S ffffffc000000000 010 4 8 ffffffc000000010 0
L 0000004000000000 003 2 8 0000004000000003 1
S 0000004000000000 004 6 8 0000004000000004 1
L 0000008000000000 000 0 8 0000008000000000 2
S 0000000000000800 800 5 8 0000000000000000 0
L 0000000000000000 ffc 4 8 fffffffffffffffc 0
S 00007fffffffffff 001 1 8 0000800000000000 2
# SV48, upper bits must copy bit 47
L 00007ffffffffff8 000 6 9 00007ffffffffff8 0
S 00007ffffffffff8 008 6 9 0000800000000000 2
L ffff800000000000 000 4 9 ffff800000000000 0
S ffff800000000000 ffc 4 9 ffff7ffffffffffc 2
L 0000800000000000 006 4 9 0000800000000006 1
S 0000004000000000 000 6 9 0000004000000000 0
L 0001000000000000 002 3 9 0001000000000002 2
S 0000800000000000 001 2 9 0000800000000001 1
L 0000000000000ff0 7ff 6 9 00000000000017ef 1
S fffffffffffff000 fff 0 9 ffffffffffffefff 0

// File: bench/lsu_addr_tb.sv
/* Testbench for the LSU address stage: golden file reader, issue and completion
   drivers, compare tasks, back-pressure and flush checks, watchdog */
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module lsu_addr_tb;
    import lsu_pkg::*;

    localparam int MAX_LINES       = 64;
    localparam int CYCLES_PER_LINE = 200;

    logic                    clk_i = 1'b0;
    logic                    rst_n_i;
    logic                    flush_i;
    satp_mode_t              vm_mode_i;
    logic                    ld_iss_req_i, st_iss_req_i;
    logic                    ld_iss_ack_o, st_iss_ack_o;
    logic [`LSU_XLEN-1:0]    ld_iss_rs1_i, st_iss_rs1_i;
    logic [`LSU_I_IMM-1:0]   ld_iss_imm_i, st_iss_imm_i;
    ldst_type_t              ld_iss_type_i, st_iss_type_i;
    logic                    ld_cpl_req_o, st_cpl_req_o;
    logic                    ld_cpl_ack_i, st_cpl_ack_i;
    logic [`LSU_XLEN-1:0]    ld_cpl_vaddr_o, st_cpl_vaddr_o;
    vadder_except_t          ld_cpl_except_o, st_cpl_except_o;

    // Golden lines, one instruction each
    bit                    g_is_st  [MAX_LINES];
    logic [`LSU_XLEN-1:0]  g_rs1    [MAX_LINES];
    logic [`LSU_I_IMM-1:0] g_imm    [MAX_LINES];
    ldst_type_t            g_type   [MAX_LINES];
    satp_mode_t            g_mode   [MAX_LINES];
    logic [`LSU_XLEN-1:0]  g_vaddr  [MAX_LINES];
    vadder_except_t        g_except [MAX_LINES];
    int                    n_lines = 0;

    // Outstanding results per queue, in issue order
    logic [`LSU_XLEN-1:0]  ld_exp_vaddr [$];
    logic [`LSU_XLEN-1:0]  st_exp_vaddr [$];
    vadder_except_t        ld_exp_except [$];
    vadder_except_t        st_exp_except [$];

    logic [31:0] rng_state = 32'he036_1e65;
    // Completion drivers ignore requests while set
    bit          cpl_hold = 1'b0;

    lsu_addr_top uut (.*);

    always #50 clk_i = ~clk_i;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_vaddr(input string name, input logic [`LSU_XLEN-1:0] got,
                               input logic [`LSU_XLEN-1:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Fail at %0t ns: %s = %h, expected %h",
                                    $time, name, got, exp));
        end
    endtask

    task automatic check_except(input string name, input vadder_except_t got,
                                input vadder_except_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Fail at %0t ns: %s = %0d, expected %0d",
                                    $time, name, got, exp));
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Random value in 0 .. bound-1
    function automatic int next_random(input int bound);
        rng_state = xorshift32(rng_state);
        return int'(rng_state % bound);
    endfunction

    function automatic logic iss_ack(input bit is_st);
        return is_st ? st_iss_ack_o : ld_iss_ack_o;
    endfunction

    function automatic logic cpl_req(input bit is_st);
        return is_st ? st_cpl_req_o : ld_cpl_req_o;
    endfunction

    // Index of the k-th load or store line, -1 if missing
    function automatic int nth_line(input bit is_st, input int k);
        int seen;
        seen = 0;
        for (int i = 0; i < n_lines; i++) begin
            if (g_is_st[i] == is_st) begin
                if (seen == k) return i;
                seen++;
            end
        end
        return -1;
    endfunction

    task automatic read_golden();
        int                    fd;
        int                    code;
        int                    typ;
        int                    mode;
        int                    exc;
        logic [7:0]            c;
        logic [`LSU_XLEN-1:0]  rs1;
        logic [`LSU_XLEN-1:0]  vaddr;
        logic [`LSU_I_IMM-1:0] imm;
        logic [8*256-1:0]      skip;
        fd = $fopen("bench/lsu_addr_golden.txt", "r");
        if (fd == 0) begin
            stop_on_error("Cannot open bench/lsu_addr_golden.txt");
        end
        // First character of a line is the flag or a comment mark
        while ($fscanf(fd, " %c", c) == 1) begin
            if (c == "#") begin
                code = $fgets(skip, fd);
            end else if ((c == "L" || c == "S") && n_lines < MAX_LINES) begin
                code = $fscanf(fd, "%h %h %d %d %h %d", rs1, imm, typ, mode, vaddr, exc);
                if (code != 6) begin
                    stop_on_error("Malformed line in the golden file");
                end
                g_is_st[n_lines]  = (c == "S");
                g_rs1[n_lines]    = rs1;
                g_imm[n_lines]    = imm;
                g_type[n_lines]   = ldst_type_t'(typ);
                g_mode[n_lines]   = satp_mode_t'(mode);
                g_vaddr[n_lines]  = vaddr;
                g_except[n_lines] = vadder_except_t'(exc);
                n_lines++;
            end else begin
                stop_on_error("Unknown flag or too many lines in the golden file");
            end
        end
        $fclose(fd);
    endtask

    // Four-phase issue of one golden line, called right after a rising edge
    task automatic issue_one(input bit is_st, input int idx, input bit expect_cpl);
        repeat (next_random(4)) @(posedge clk_i);
        if (expect_cpl && is_st) begin
            st_exp_vaddr.push_back(g_vaddr[idx]);
            st_exp_except.push_back(g_except[idx]);
        end else if (expect_cpl) begin
            ld_exp_vaddr.push_back(g_vaddr[idx]);
            ld_exp_except.push_back(g_except[idx]);
        end
        if (is_st) begin
            st_iss_req_i  <= 1'b1;
            st_iss_rs1_i  <= g_rs1[idx];
            st_iss_imm_i  <= g_imm[idx];
            st_iss_type_i <= g_type[idx];
        end else begin
            ld_iss_req_i  <= 1'b1;
            ld_iss_rs1_i  <= g_rs1[idx];
            ld_iss_imm_i  <= g_imm[idx];
            ld_iss_type_i <= g_type[idx];
        end
        do @(posedge clk_i); while (iss_ack(is_st) !== 1'b1);
        if (is_st) st_iss_req_i <= 1'b0;
        else ld_iss_req_i <= 1'b0;
        do @(posedge clk_i); while (iss_ack(is_st) !== 1'b0);
    endtask

    task automatic issue_range(input bit is_st, input int lo, input int hi,
                               input bit expect_cpl);
        for (int i = lo; i < hi; i++) begin
            if (g_is_st[i] == is_st) begin
                issue_one(is_st, i, expect_cpl);
            end
        end
    endtask

    // Takes one completion at a time, checks it, acks after a random delay
    task automatic complete_port(input bit is_st);
        logic [`LSU_XLEN-1:0] exp_vaddr;
        vadder_except_t       exp_except;
        forever begin
            @(posedge clk_i);
            if (cpl_req(is_st) && !cpl_hold) begin
                if ((is_st ? st_exp_vaddr.size() : ld_exp_vaddr.size()) == 0) begin
                    stop_on_error("Completion request with no instruction outstanding");
                end
                if (is_st) begin
                    exp_vaddr  = st_exp_vaddr.pop_front();
                    exp_except = st_exp_except.pop_front();
                    check_vaddr("st_cpl_vaddr_o", st_cpl_vaddr_o, exp_vaddr);
                    check_except("st_cpl_except_o", st_cpl_except_o, exp_except);
                end else begin
                    exp_vaddr  = ld_exp_vaddr.pop_front();
                    exp_except = ld_exp_except.pop_front();
                    check_vaddr("ld_cpl_vaddr_o", ld_cpl_vaddr_o, exp_vaddr);
                    check_except("ld_cpl_except_o", ld_cpl_except_o, exp_except);
                end
                repeat (next_random(8)) @(posedge clk_i);
                if (is_st) st_cpl_ack_i <= 1'b1;
                else ld_cpl_ack_i <= 1'b1;
                do @(posedge clk_i); while (cpl_req(is_st));
                if (is_st) st_cpl_ack_i <= 1'b0;
                else ld_cpl_ack_i <= 1'b0;
            end
        end
    endtask

    // Both ports idle and nothing left to complete
    task automatic wait_drain();
        do @(posedge clk_i);
        while (ld_exp_vaddr.size() != 0 || st_exp_vaddr.size() != 0 ||
               ld_cpl_req_o || ld_cpl_ack_i || st_cpl_req_o || st_cpl_ack_i);
    endtask

    // Lines of one paging mode, loads and stores issued side by side
    task automatic run_group(input int lo, input int hi);
        @(posedge clk_i);
        vm_mode_i <= g_mode[lo];
        fork
            issue_range(1'b0, lo, hi, 1'b1);
            issue_range(1'b1, lo, hi, 1'b1);
        join
        wait_drain();
    endtask

    // Fill both queues with completions withheld, one more issue must stall
    task automatic check_backpressure();
        if (nth_line(1'b0, `LSU_QDEPTH) < 0 || nth_line(1'b1, `LSU_QDEPTH) < 0) begin
            stop_on_error("Golden file too short for the back-pressure test");
        end
        @(posedge clk_i);
        vm_mode_i <= g_mode[nth_line(1'b0, 0)];
        cpl_hold = 1'b1;
        fork
            for (int k = 0; k < `LSU_QDEPTH; k++) begin
                issue_one(1'b0, nth_line(1'b0, k), 1'b1);
            end
            for (int k = 0; k < `LSU_QDEPTH; k++) begin
                issue_one(1'b1, nth_line(1'b1, k), 1'b1);
            end
        join
        fork
            issue_one(1'b0, nth_line(1'b0, `LSU_QDEPTH), 1'b1);
            issue_one(1'b1, nth_line(1'b1, `LSU_QDEPTH), 1'b1);
            begin
                repeat (20) begin
                    @(posedge clk_i);
                    if (ld_iss_ack_o || st_iss_ack_o) begin
                        stop_on_error("Issue acknowledged while the queue was full");
                    end
                end
                cpl_hold = 1'b0;
            end
        join
        wait_drain();
    endtask

    // Flushed work must never complete, later work must
    task automatic check_flush(input int lo, input int hi);
        @(posedge clk_i);
        vm_mode_i <= g_mode[lo];
        cpl_hold = 1'b1;
        fork
            for (int k = 0; k < 3; k++) begin
                issue_one(1'b0, nth_line(1'b0, k), 1'b0);
            end
            for (int k = 0; k < 2; k++) begin
                issue_one(1'b1, nth_line(1'b1, k), 1'b0);
            end
        join
        repeat (2) @(posedge clk_i);
        flush_i <= 1'b1;
        @(posedge clk_i);
        flush_i <= 1'b0;
        repeat (12) begin
            @(posedge clk_i);
            if (ld_cpl_req_o || st_cpl_req_o) begin
                stop_on_error("Completion request raised for a flushed instruction");
            end
        end
        cpl_hold = 1'b0;
        run_group(lo, hi);
    endtask

    initial complete_port(1'b0);
    initial complete_port(1'b1);

    // Budget grows with the golden file
    initial begin
        wait (n_lines > 0);
        repeat (n_lines * CYCLES_PER_LINE) @(posedge clk_i);
        stop_on_error("Watchdog timeout, completions stopped arriving");
    end

    initial begin
        int lo;
        int hi;
        int first_hi;
        rst_n_i       = 1'b0;
        flush_i       = 1'b0;
        vm_mode_i     = BARE;
        ld_iss_req_i  = 1'b0;
        ld_iss_rs1_i  = '0;
        ld_iss_imm_i  = '0;
        ld_iss_type_i = LS_BYTE;
        ld_cpl_ack_i  = 1'b0;
        st_iss_req_i  = 1'b0;
        st_iss_rs1_i  = '0;
        st_iss_imm_i  = '0;
        st_iss_type_i = LS_BYTE;
        st_cpl_ack_i  = 1'b0;
        read_golden();
        if (n_lines == 0) begin
            stop_on_error("Golden file holds no instructions");
        end
        repeat (3) @(posedge clk_i);
        rst_n_i <= 1'b1;
        // Mode changes only between groups, with both queues empty
        lo       = 0;
        first_hi = 0;
        while (lo < n_lines) begin
            hi = lo;
            while (hi < n_lines && g_mode[hi] == g_mode[lo]) hi++;
            if (lo == 0) first_hi = hi;
            run_group(lo, hi);
            lo = hi;
        end
        check_backpressure();
        check_flush(0, first_hi);
        $display("Verification passed");
        $finish;
    end

endmodule

// File: hdl/agu_arbiter.sv
/* Round-robin arbiter sharing the address adder between the load and store
   queues, with result steering back to the owner */
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module agu_arbiter (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    // Requests and grants
    input  logic                        ld_req_i,
    input  logic                        st_req_i,
    output logic                        ld_gnt_o,
    output logic                        st_gnt_o,
    // Load queue operands
    input  logic [`LSU_IDX_LEN-1:0]     ld_idx_i,
    input  logic [`LSU_XLEN-1:0]        ld_rs1_i,
    input  logic [`LSU_I_IMM-1:0]       ld_imm_i,
    input  lsu_pkg::ldst_type_t         ld_type_i,
    // Store queue operands
    input  logic [`LSU_IDX_LEN-1:0]     st_idx_i,
    input  logic [`LSU_XLEN-1:0]        st_rs1_i,
    input  logic [`LSU_I_IMM-1:0]       st_imm_i,
    input  lsu_pkg::ldst_type_t         st_type_i,
    // To the adder
    output logic                        agu_valid_o,
    output logic                        agu_owner_o,
    output logic [`LSU_IDX_LEN-1:0]     agu_idx_o,
    output logic [`LSU_XLEN-1:0]        agu_rs1_o,
    output logic [`LSU_I_IMM-1:0]       agu_imm_o,
    output lsu_pkg::ldst_type_t         agu_type_o,
    // Result from the adder and strobes to the queues
    input  logic                        res_valid_i,
    input  logic                        res_owner_i,
    output logic                        ld_res_o,
    output logic                        st_res_o
);

    // High when the store queue won the last grant
    logic last_st_q;
    logic pick_st;

    // On a tie the queue not served last wins
    always_comb begin
        if (ld_req_i && st_req_i) begin
            pick_st = !last_st_q;
        end else begin
            pick_st = st_req_i;
        end
    end

    assign ld_gnt_o = ld_req_i & ~pick_st;
    assign st_gnt_o = st_req_i & pick_st;

    // Starts as store so the first tie goes to loads
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            last_st_q <= 1'b1;
        end else if (ld_gnt_o || st_gnt_o) begin
            last_st_q <= st_gnt_o;
        end
    end

    // Winner's operands to the adder, owner high for stores
    assign agu_valid_o = ld_gnt_o | st_gnt_o;
    assign agu_owner_o = st_gnt_o;
    assign agu_idx_o   = pick_st ? st_idx_i : ld_idx_i;
    assign agu_rs1_o   = pick_st ? st_rs1_i : ld_rs1_i;
    assign agu_imm_o   = pick_st ? st_imm_i : ld_imm_i;
    assign agu_type_o  = pick_st ? st_type_i : ld_type_i;

    // Result valid back to the owning queue
    assign ld_res_o = res_valid_i & ~res_owner_i;
    assign st_res_o = res_valid_i & res_owner_i;

endmodule

// File: hdl/lsu_addr_queue.sv
/* In-order address queue: four-phase issue port, adder request/grant,
   result capture by index and four-phase in-order completion port */
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module lsu_addr_queue #(
    parameter int DEPTH = `LSU_QDEPTH
) (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        flush_i,
    // Issue port, four-phase
    input  logic                        iss_req_i,
    output logic                        iss_ack_o,
    input  logic [`LSU_XLEN-1:0]        iss_rs1_i,
    input  logic [`LSU_I_IMM-1:0]       iss_imm_i,
    input  lsu_pkg::ldst_type_t         iss_type_i,
    // Adder request, oldest waiting entry
    output logic                        agu_req_o,
    input  logic                        agu_gnt_i,
    output logic [`LSU_IDX_LEN-1:0]     agu_idx_o,
    output logic [`LSU_XLEN-1:0]        agu_rs1_o,
    output logic [`LSU_I_IMM-1:0]       agu_imm_o,
    output lsu_pkg::ldst_type_t         agu_type_o,
    // Adder result, strobe selects this queue
    input  logic                        res_strobe_i,
    input  logic [`LSU_IDX_LEN-1:0]     res_idx_i,
    input  logic [`LSU_XLEN-1:0]        res_vaddr_i,
    input  lsu_pkg::vadder_except_t     res_except_i,
    // Completion port, four-phase
    output logic                        cpl_req_o,
    input  logic                        cpl_ack_i,
    output logic [`LSU_XLEN-1:0]        cpl_vaddr_o,
    output lsu_pkg::vadder_except_t     cpl_except_o
);
    import lsu_pkg::*;

    // Per-slot state and payload
    entry_state_t          state_q  [DEPTH];
    logic [`LSU_XLEN-1:0]  rs1_q    [DEPTH];
    logic [`LSU_I_IMM-1:0] imm_q    [DEPTH];
    ldst_type_t            type_q   [DEPTH];
    logic [`LSU_XLEN-1:0]  vaddr_q  [DEPTH];
    vadder_except_t        except_q [DEPTH];

    // Head is the oldest entry, tail the next free slot
    logic [`LSU_IDX_LEN-1:0] head_q;
    logic [`LSU_IDX_LEN-1:0] tail_q;
    logic [`LSU_IDX_LEN-1:0] wait_idx;
    logic                    full;
    logic                    iss_accept;
    logic                    cpl_done;

    function automatic logic [`LSU_IDX_LEN-1:0] next_ptr(input logic [`LSU_IDX_LEN-1:0] p);
        next_ptr = (p == DEPTH-1) ? '0 : p + 1'b1;
    endfunction

    // Tail slot still busy means every slot is in use
    assign full       = (state_q[tail_q] != ST_EMPTY);
    assign iss_accept = iss_req_i & ~iss_ack_o & ~full & ~flush_i;
    assign cpl_done   = cpl_req_o & cpl_ack_i;

    // Oldest waiting entry, scanned from head so the nearest one wins
    always_comb begin
        int unsigned slot;
        agu_req_o = 1'b0;
        wait_idx  = head_q;
        for (int i = DEPTH-1; i >= 0; i--) begin
            slot = (head_q + i) % DEPTH;
            if (state_q[slot] == ST_WAIT_AGU) begin
                agu_req_o = 1'b1;
                wait_idx  = `LSU_IDX_LEN'(slot);
            end
        end
    end

    assign agu_idx_o  = wait_idx;
    assign agu_rs1_o  = rs1_q[wait_idx];
    assign agu_imm_o  = imm_q[wait_idx];
    assign agu_type_o = type_q[wait_idx];

    // Completion data always follows the head
    assign cpl_vaddr_o  = vaddr_q[head_q];
    assign cpl_except_o = except_q[head_q];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                state_q[i] <= ST_EMPTY;
            end
            head_q    <= '0;
            tail_q    <= '0;
            iss_ack_o <= 1'b0;
            cpl_req_o <= 1'b0;
        end else if (flush_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                state_q[i] <= ST_EMPTY;
            end
            head_q    <= '0;
            tail_q    <= '0;
            cpl_req_o <= 1'b0;
            // Let a pending issue handshake finish
            iss_ack_o <= iss_ack_o & iss_req_i;
        end else begin
            // Issue: write a free slot, ack until req falls
            if (iss_accept) begin
                state_q[tail_q] <= ST_WAIT_AGU;
                tail_q          <= next_ptr(tail_q);
                iss_ack_o       <= 1'b1;
            end else if (!iss_req_i) begin
                iss_ack_o <= 1'b0;
            end
            if (agu_gnt_i) begin
                state_q[wait_idx] <= ST_IN_AGU;
            end
            if (res_strobe_i) begin
                state_q[res_idx_i] <= ST_DONE;
            end
            // Completion: free head on ack, rise again only after ack low
            if (cpl_done) begin
                state_q[head_q] <= ST_EMPTY;
                head_q          <= next_ptr(head_q);
                cpl_req_o       <= 1'b0;
            end else if (!cpl_req_o && !cpl_ack_i && state_q[head_q] == ST_DONE) begin
                cpl_req_o <= 1'b1;
            end
        end
    end

    // Payload storage
    always_ff @(posedge clk_i) begin
        if (iss_accept) begin
            rs1_q[tail_q]  <= iss_rs1_i;
            imm_q[tail_q]  <= iss_imm_i;
            type_q[tail_q] <= iss_type_i;
        end
        if (res_strobe_i) begin
            vaddr_q[res_idx_i]  <= res_vaddr_i;
            except_q[res_idx_i] <= res_except_i;
        end
    end

endmodule

// File: hdl/lsu_addr_top.sv
/* Address generation stage top: load and store queues, adder arbiter and
   shared virtual address adder */
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module lsu_addr_top (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        flush_i,
    input  lsu_pkg::satp_mode_t         vm_mode_i,
    // Load issue
    input  logic                        ld_iss_req_i,
    output logic                        ld_iss_ack_o,
    input  logic [`LSU_XLEN-1:0]        ld_iss_rs1_i,
    input  logic [`LSU_I_IMM-1:0]       ld_iss_imm_i,
    input  lsu_pkg::ldst_type_t         ld_iss_type_i,
    // Load completion
    output logic                        ld_cpl_req_o,
    input  logic                        ld_cpl_ack_i,
    output logic [`LSU_XLEN-1:0]        ld_cpl_vaddr_o,
    output lsu_pkg::vadder_except_t     ld_cpl_except_o,
    // Store issue
    input  logic                        st_iss_req_i,
    output logic                        st_iss_ack_o,
    input  logic [`LSU_XLEN-1:0]        st_iss_rs1_i,
    input  logic [`LSU_I_IMM-1:0]       st_iss_imm_i,
    input  lsu_pkg::ldst_type_t         st_iss_type_i,
    // Store completion
    output logic                        st_cpl_req_o,
    input  logic                        st_cpl_ack_i,
    output logic [`LSU_XLEN-1:0]        st_cpl_vaddr_o,
    output lsu_pkg::vadder_except_t     st_cpl_except_o
);
    import lsu_pkg::*;

    // Queue to arbiter
    logic                    ld_agu_req, st_agu_req;
    logic                    ld_agu_gnt, st_agu_gnt;
    logic [`LSU_IDX_LEN-1:0] ld_agu_idx, st_agu_idx;
    logic [`LSU_XLEN-1:0]    ld_agu_rs1, st_agu_rs1;
    logic [`LSU_I_IMM-1:0]   ld_agu_imm, st_agu_imm;
    ldst_type_t              ld_agu_type, st_agu_type;

    // Arbiter to adder
    logic                    agu_valid;
    logic                    agu_owner;
    logic [`LSU_IDX_LEN-1:0] agu_idx;
    logic [`LSU_XLEN-1:0]    agu_rs1;
    logic [`LSU_I_IMM-1:0]   agu_imm;
    ldst_type_t              agu_type;

    // Adder result, shared by both queues
    logic                    res_valid;
    logic                    res_owner;
    logic [`LSU_IDX_LEN-1:0] res_idx;
    logic [`LSU_XLEN-1:0]    res_vaddr;
    vadder_except_t          res_except;
    logic                    ld_res, st_res;

    lsu_addr_queue #(.DEPTH(`LSU_QDEPTH)) u_ld_queue (
        .clk_i, .rst_n_i, .flush_i,
        .iss_req_i(ld_iss_req_i), .iss_ack_o(ld_iss_ack_o),
        .iss_rs1_i(ld_iss_rs1_i), .iss_imm_i(ld_iss_imm_i), .iss_type_i(ld_iss_type_i),
        .agu_req_o(ld_agu_req), .agu_gnt_i(ld_agu_gnt), .agu_idx_o(ld_agu_idx),
        .agu_rs1_o(ld_agu_rs1), .agu_imm_o(ld_agu_imm), .agu_type_o(ld_agu_type),
        .res_strobe_i(ld_res), .res_idx_i(res_idx),
        .res_vaddr_i(res_vaddr), .res_except_i(res_except),
        .cpl_req_o(ld_cpl_req_o), .cpl_ack_i(ld_cpl_ack_i),
        .cpl_vaddr_o(ld_cpl_vaddr_o), .cpl_except_o(ld_cpl_except_o)
    );

    lsu_addr_queue #(.DEPTH(`LSU_QDEPTH)) u_st_queue (
        .clk_i, .rst_n_i, .flush_i,
        .iss_req_i(st_iss_req_i), .iss_ack_o(st_iss_ack_o),
        .iss_rs1_i(st_iss_rs1_i), .iss_imm_i(st_iss_imm_i), .iss_type_i(st_iss_type_i),
        .agu_req_o(st_agu_req), .agu_gnt_i(st_agu_gnt), .agu_idx_o(st_agu_idx),
        .agu_rs1_o(st_agu_rs1), .agu_imm_o(st_agu_imm), .agu_type_o(st_agu_type),
        .res_strobe_i(st_res), .res_idx_i(res_idx),
        .res_vaddr_i(res_vaddr), .res_except_i(res_except),
        .cpl_req_o(st_cpl_req_o), .cpl_ack_i(st_cpl_ack_i),
        .cpl_vaddr_o(st_cpl_vaddr_o), .cpl_except_o(st_cpl_except_o)
    );

    agu_arbiter u_agu_arbiter (
        .clk_i, .rst_n_i,
        .ld_req_i(ld_agu_req), .st_req_i(st_agu_req),
        .ld_gnt_o(ld_agu_gnt), .st_gnt_o(st_agu_gnt),
        .ld_idx_i(ld_agu_idx), .ld_rs1_i(ld_agu_rs1),
        .ld_imm_i(ld_agu_imm), .ld_type_i(ld_agu_type),
        .st_idx_i(st_agu_idx), .st_rs1_i(st_agu_rs1),
        .st_imm_i(st_agu_imm), .st_type_i(st_agu_type),
        .agu_valid_o(agu_valid), .agu_owner_o(agu_owner), .agu_idx_o(agu_idx),
        .agu_rs1_o(agu_rs1), .agu_imm_o(agu_imm), .agu_type_o(agu_type),
        .res_valid_i(res_valid), .res_owner_i(res_owner),
        .ld_res_o(ld_res), .st_res_o(st_res)
    );

    vaddr_adder u_vaddr_adder (
        .clk_i, .rst_n_i, .flush_i, .vm_mode_i,
        .in_valid_i(agu_valid), .in_owner_i(agu_owner), .in_idx_i(agu_idx),
        .rs1_i(agu_rs1), .imm_i(agu_imm), .type_i(agu_type),
        .out_valid_o(res_valid), .out_owner_o(res_owner), .out_idx_o(res_idx),
        .vaddr_o(res_vaddr), .except_o(res_except)
    );

endmodule

// File: hdl/lsu_cfg.svh
/* Configuration macros for the LSU address stage: data width, immediate width,
   queue depth and entry index width */
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// Data and virtual address width
`define LSU_XLEN 64

// I-type immediate width
`define LSU_I_IMM 12

// Entries per address queue
`define LSU_QDEPTH 4

// Entry index width, must cover LSU_QDEPTH
`define LSU_IDX_LEN 2

`endif

// File: hdl/lsu_pkg.sv
/* LSU package: access type, paging mode, adder exception and queue entry state */
package lsu_pkg;

    // Load/store access width and signedness
    typedef enum logic [2:0] {
        LS_BYTE       = 3'd0,
        LS_BYTE_U     = 3'd1,
        LS_HALFWORD   = 3'd2,
        LS_HALFWORD_U = 3'd3,
        LS_WORD       = 3'd4,
        LS_WORD_U     = 3'd5,
        LS_DOUBLEWORD = 3'd6
    } ldst_type_t;

    // Paging mode, same encoding as the satp MODE field
    typedef enum logic [3:0] {
        BARE = 4'd0,
        SV39 = 4'd8,
        SV48 = 4'd9
    } satp_mode_t;

    // Exception raised by the address adder
    // Misaligned wins over page fault
    typedef enum logic [1:0] {
        VADDER_NO_EXCEPT    = 2'd0,
        VADDER_ALIGN_EXCEPT = 2'd1,
        VADDER_PAGE_EXCEPT  = 2'd2
    } vadder_except_t;

    // Life of one address queue slot
    // Empty, waiting for the adder, inside the adder, result ready
    typedef enum logic [1:0] {
        ST_EMPTY    = 2'd0,
        ST_WAIT_AGU = 2'd1,
        ST_IN_AGU   = 2'd2,
        ST_DONE     = 2'd3
    } entry_state_t;

endpackage

// File: hdl/vaddr_adder.sv
/* Registered virtual address adder with alignment and canonical-address checks,
   returning each result tagged with owner and entry index */
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module vaddr_adder (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        flush_i,
    // Paging mode, sampled with the operands
    input  lsu_pkg::satp_mode_t         vm_mode_i,
    // Operands from the arbiter
    input  logic                        in_valid_i,
    input  logic                        in_owner_i,
    input  logic [`LSU_IDX_LEN-1:0]     in_idx_i,
    input  logic [`LSU_XLEN-1:0]        rs1_i,
    input  logic [`LSU_I_IMM-1:0]       imm_i,
    input  lsu_pkg::ldst_type_t         type_i,
    // Result, valid one cycle after the operands
    output logic                        out_valid_o,
    output logic                        out_owner_o,
    output logic [`LSU_IDX_LEN-1:0]     out_idx_o,
    output logic [`LSU_XLEN-1:0]        vaddr_o,
    output lsu_pkg::vadder_except_t     except_o
);
    import lsu_pkg::*;

    logic [`LSU_XLEN-1:0]  rs1_q;
    logic [`LSU_I_IMM-1:0] imm_q;
    logic [`LSU_XLEN-1:0]  sext_imm;
    ldst_type_t            type_q;
    satp_mode_t            vm_mode_q;
    logic                  align_err;
    logic                  page_err;

    // Result valid, a flush kills the operation in flight
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_valid_o <= 1'b0;
        end else if (flush_i) begin
            out_valid_o <= 1'b0;
        end else begin
            out_valid_o <= in_valid_i;
        end
    end

    // Operand and tag registers, loaded only on a granted request
    always_ff @(posedge clk_i) begin
        if (in_valid_i) begin
            out_owner_o <= in_owner_i;
            out_idx_o   <= in_idx_i;
            rs1_q       <= rs1_i;
            imm_q       <= imm_i;
            type_q      <= type_i;
            vm_mode_q   <= vm_mode_i;
        end
    end

    // Sign-extend the immediate and add
    assign sext_imm = {{(`LSU_XLEN-`LSU_I_IMM){imm_q[`LSU_I_IMM-1]}}, imm_q};
    assign vaddr_o  = rs1_q + sext_imm;

    always_comb begin
        // Upper bits must copy the top translated bit
        case (vm_mode_q)
            SV39:    page_err = (vaddr_o[`LSU_XLEN-1:39] != {(`LSU_XLEN-39){vaddr_o[38]}});
            SV48:    page_err = (vaddr_o[`LSU_XLEN-1:48] != {(`LSU_XLEN-48){vaddr_o[47]}});
            default: page_err = 1'b0;
        endcase
        // Natural alignment per access width, bytes always aligned
        case (type_q)
            LS_HALFWORD, LS_HALFWORD_U: align_err = vaddr_o[0];
            LS_WORD, LS_WORD_U:         align_err = (vaddr_o[1:0] != 2'b00);
            LS_DOUBLEWORD:              align_err = (vaddr_o[2:0] != 3'b000);
            default:                    align_err = 1'b0;
        endcase
        // Misaligned has priority over page fault
        if (align_err) begin
            except_o = VADDER_ALIGN_EXCEPT;
        end else if (page_err) begin
            except_o = VADDER_PAGE_EXCEPT;
        end else begin
            except_o = VADDER_NO_EXCEPT;
        end
    end

endmodule

// File: lsu_addr_top.f
+incdir+hdl
hdl/lsu_pkg.sv
hdl/vaddr_adder.sv
hdl/agu_arbiter.sv
hdl/lsu_addr_queue.sv
hdl/lsu_addr_top.sv
bench/lsu_addr_tb.sv
